//--- all.f
+incdir+include
hw/dcache_pkg.sv
hw/way_if.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

//--- hw/dcache_ctrl.sv
`timescale 1ns/10ps

`include "dcache_cfg.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,

    way_if.ctrl way0,
    way_if.ctrl way1,

    // cpu side
    input logic req_valid_i,
    input logic req_we_i,
    input addr_t req_addr_i,
    input wstrb_t req_wstrb_i,
    input word_t req_wdata_i,
    output logic stall_o,
    output word_t rdata_o,
    output logic rdata_valid_o,

    // memory side
    output logic rd_req_o,
    output addr_t rd_addr_o,
    input logic ret_valid_i,
    input line_t ret_data_i,
    output logic wr_req_o,
    output addr_t wr_addr_o,
    output line_t wr_data_o
);

    localparam int SETS = 1 << `DC_INDEX_W;

    // request stage
    logic req_valid_q;
    logic req_we_q;
    addr_t req_addr_q;
    wstrb_t req_wstrb_q;
    word_t req_wdata_q;

    tag_t tag_q;
    index_t index_q;
    logic [`DC_OFFSET_W-3:0] word_sel;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic [SETS-1:0] lru_q;

    logic hit_any;
    logic run_hit;
    logic write_hit;
    logic miss;
    logic refill_done;
    logic req_done;

    logic victim;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
    line_t victim_line;

    line_t hit_line;
    line_t base_line;
    line_t install_line;
    line_t data_line;

    // drop the strobed bytes of the store into one word of a line
    function automatic line_t merge_line(line_t base, logic [`DC_OFFSET_W-3:0] sel,
                                         wstrb_t strb, word_t data);
        line_t merged;
        merged = base;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[sel*32 + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign tag_q = req_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index_q = req_addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word_sel = req_addr_q[`DC_OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else if (!stall_o) begin
            req_valid_q <= req_valid_i;
        end else if (req_done) begin
            req_valid_q <= 1'b0;   // bubble so the next lookup sees the new line
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            req_we_q <= req_we_i;
            req_addr_q <= req_addr_i;
            req_wstrb_q <= req_wstrb_i;
            req_wdata_q <= req_wdata_i;
        end
    end

    // hit combining
    assign hit_any = way0.hit || way1.hit;
    assign run_hit = (state_q == CS_RUN) && req_valid_q && hit_any;
    assign write_hit = run_hit && req_we_q;
    assign miss = (state_q == CS_RUN) && req_valid_q && !hit_any;
    assign refill_done = (state_q == CS_REFILL) && ret_valid_i;
    assign req_done = write_hit || refill_done;

    assign stall_o = (state_q != CS_RUN) || (req_valid_q && (req_we_q || !hit_any));

    assign hit_line = way1.hit ? way1.rd_line : way0.rd_line;

    // read data, from the hit way or straight off the refill
    assign data_line = (state_q == CS_REFILL) ? ret_data_i : hit_line;
    assign rdata_o = data_line[word_sel*32 +: 32];
    assign rdata_valid_o = (run_hit && !req_we_q) || (refill_done && !req_we_q);

    // lru bit names the way to replace next
    assign victim = lru_q[index_q];
    assign victim_valid = victim ? way1.valid : way0.valid;
    assign victim_dirty = victim ? way1.dirty : way0.dirty;
    assign victim_tag = victim ? way1.rd_tag : way0.rd_tag;
    assign victim_line = victim ? way1.rd_line : way0.rd_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (run_hit) begin
            lru_q[index_q] <= way0.hit;
        end else if (refill_done) begin
            lru_q[index_q] <= ~victim;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            CS_RUN: begin
                if (miss) begin
                    state_d = (victim_valid && victim_dirty) ? CS_WRITEBACK : CS_REFILL;
                end
            end
            CS_WRITEBACK: state_d = CS_REFILL;
            CS_REFILL: begin
                if (ret_valid_i) begin
                    state_d = CS_RUN;
                end
            end
            default: state_d = CS_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= CS_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // memory port
    assign wr_req_o = (state_q == CS_WRITEBACK);
    assign wr_addr_o = {victim_tag, index_q, {`DC_OFFSET_W{1'b0}}};
    assign wr_data_o = victim_line;
    assign rd_req_o = (state_q == CS_REFILL);
    assign rd_addr_o = {tag_q, index_q, {`DC_OFFSET_W{1'b0}}};

    // store merge, same path for write hit and write miss
    assign base_line = refill_done ? ret_data_i : hit_line;
    assign install_line = req_we_q ? merge_line(base_line, word_sel, req_wstrb_q, req_wdata_q)
                                   : base_line;

    // lookups stay on the held request while stalled
    assign way0.lookup_index = stall_o ? index_q : req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign way1.lookup_index = stall_o ? index_q : req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign way0.lookup_tag = tag_q;
    assign way1.lookup_tag = tag_q;

    assign way0.wr_en = (write_hit && way0.hit) || (refill_done && !victim);
    assign way1.wr_en = (write_hit && way1.hit) || (refill_done && victim);
    assign way0.wr_index = index_q;
    assign way1.wr_index = index_q;
    assign way0.wr_tag = tag_q;
    assign way1.wr_tag = tag_q;
    assign way0.wr_line = install_line;
    assign way1.wr_line = install_line;
    assign way0.wr_dirty = req_we_q;   // clean only for a read refill
    assign way1.wr_dirty = req_we_q;

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

`include "dcache_cfg.svh"

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] wstrb_t;   // one bit per byte lane
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;

    // word 0 in the low bits
    typedef logic [`DC_WORDS*32-1:0] line_t;

    typedef enum logic [1:0] {
        CS_RUN,
        CS_WRITEBACK,
        CS_REFILL
    } ctrl_state_e;

endpackage

//--- hw/dcache_top.sv
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic req_valid_i,
    input logic req_we_i,
    input addr_t req_addr_i,
    input wstrb_t req_wstrb_i,
    input word_t req_wdata_i,
    output logic stall_o,
    output word_t rdata_o,
    output logic rdata_valid_o,

    output logic rd_req_o,
    output addr_t rd_addr_o,
    input logic ret_valid_i,
    input line_t ret_data_i,
    output logic wr_req_o,
    output addr_t wr_addr_o,
    output line_t wr_data_o
);

    way_if way0_bus();
    way_if way1_bus();

    dcache_way way0_u (
        .clk(clk),
        .reset(reset),
        .bus(way0_bus.way)
    );

    dcache_way way1_u (
        .clk(clk),
        .reset(reset),
        .bus(way1_bus.way)
    );

    dcache_ctrl ctrl_u (
        .clk(clk),
        .reset(reset),
        .way0(way0_bus.ctrl),
        .way1(way1_bus.ctrl),
        .req_valid_i(req_valid_i),
        .req_we_i(req_we_i),
        .req_addr_i(req_addr_i),
        .req_wstrb_i(req_wstrb_i),
        .req_wdata_i(req_wdata_i),
        .stall_o(stall_o),
        .rdata_o(rdata_o),
        .rdata_valid_o(rdata_valid_o),
        .rd_req_o(rd_req_o),
        .rd_addr_o(rd_addr_o),
        .ret_valid_i(ret_valid_i),
        .ret_data_i(ret_data_i),
        .wr_req_o(wr_req_o),
        .wr_addr_o(wr_addr_o),
        .wr_data_o(wr_data_o)
    );

endmodule

//--- hw/dcache_way.sv
`timescale 1ns/10ps

`include "dcache_cfg.svh"

module dcache_way
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,
    way_if.way bus
);

    localparam int SETS = 1 << `DC_INDEX_W;

    tag_t tag_mem [SETS];
    line_t line_mem [SETS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // registered read port
    tag_t rd_tag_q;
    line_t rd_line_q;
    logic rd_valid_q;
    logic rd_dirty_q;

    // payload arrays
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            tag_mem[bus.wr_index] <= bus.wr_tag;
            line_mem[bus.wr_index] <= bus.wr_line;
        end
        rd_tag_q <= tag_mem[bus.lookup_index];   // old contents on a same-edge write
        rd_line_q <= line_mem[bus.lookup_index];
    end

    // state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (bus.wr_en) begin
                valid_q[bus.wr_index] <= 1'b1;
                dirty_q[bus.wr_index] <= bus.wr_dirty;
            end
            rd_valid_q <= valid_q[bus.lookup_index];
            rd_dirty_q <= dirty_q[bus.lookup_index];
        end
    end

    // lookup_tag comes from the request stage, same cycle as the read data
    assign bus.hit = rd_valid_q && (rd_tag_q == bus.lookup_tag);

    // victim info for the controller
    assign bus.valid = rd_valid_q;
    assign bus.dirty = rd_dirty_q;
    assign bus.rd_tag = rd_tag_q;
    assign bus.rd_line = rd_line_q;

endmodule

//--- hw/way_if.sv
`timescale 1ns/10ps

interface way_if
    import dcache_pkg::*;
();
    // lookup side
    index_t lookup_index;
    tag_t lookup_tag;

    // line install / store update
    logic wr_en;
    index_t wr_index;
    tag_t wr_tag;
    line_t wr_line;
    logic wr_dirty;

    // results, one cycle after lookup_index
    logic hit;
    logic valid;
    logic dirty;
    tag_t rd_tag;
    line_t rd_line;

    modport way (
        input lookup_index, lookup_tag,
        input wr_en, wr_index, wr_tag, wr_line, wr_dirty,
        output hit, valid, dirty, rd_tag, rd_line
    );

    modport ctrl (
        output lookup_index, lookup_tag,
        output wr_en, wr_index, wr_tag, wr_line, wr_dirty,
        input hit, valid, dirty, rd_tag, rd_line
    );

endinterface

//--- include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address width
`define DC_ADDR_W 32

// 16-byte lines
`define DC_OFFSET_W 4

// 16 sets
`define DC_INDEX_W 4

// what is left of the address
`define DC_TAG_W 24

// 32-bit words per line
`define DC_WORDS 4

`endif

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f all.f -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- verification/dcache_sva.sv
`timescale 1ns/10ps

module dcache_sva (
    input logic clk,
    input logic reset,
    input logic wr_req_i,
    input logic rd_req_i,
    input logic rdata_valid_i,
    input logic req_valid_i,
    input logic req_we_i,
    input logic stall_i
);

    logic store_held;

    // a taken store stays in the request stage until stall_o drops
    always_ff @(posedge clk) begin
        if (reset) begin
            store_held <= 1'b0;
        end else if (!stall_i) begin
            store_held <= req_valid_i && req_we_i;
        end
    end

    // write-back is a single-cycle pulse
    wr_pulse_a: assert property (@(posedge clk) disable iff (reset) wr_req_i |=> !wr_req_i)
        else $error("wr_req_o held longer than one cycle");

    rd_wr_apart_a: assert property (@(posedge clk) disable iff (reset) !(rd_req_i && wr_req_i))
        else $error("rd_req_o and wr_req_o high in the same cycle");

    // stores never hand back data
    no_store_data_a: assert property (@(posedge clk) disable iff (reset)
        !(rdata_valid_i && store_held))
        else $error("rdata_valid_o high while a store is in the request stage");

endmodule

bind dcache_ctrl dcache_sva sva_u (
    .clk(clk),
    .reset(reset),
    .wr_req_i(wr_req_o),
    .rd_req_i(rd_req_o),
    .rdata_valid_i(rdata_valid_o),
    .req_valid_i(req_valid_i),
    .req_we_i(req_we_i),
    .stall_i(stall_o)
);

//--- verification/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int MAX_ACCESSES = 240;
    localparam int ACCESS_LIMIT = 16;   // cycles, enough for write-back plus refill

    logic clk = 1'b0;
    logic reset;
    logic req_valid_i;
    logic req_we_i;
    addr_t req_addr_i;
    wstrb_t req_wstrb_i;
    word_t req_wdata_i;
    logic stall_o;
    word_t rdata_o;
    logic rdata_valid_o;
    logic rd_req_o;
    addr_t rd_addr_o;
    logic ret_valid_i;
    line_t ret_data_i;
    logic wr_req_o;
    addr_t wr_addr_o;
    line_t wr_data_o;

    logic [7:0] mem [4096];    // backing store, changed only by write-backs
    logic [7:0] gold [4096];   // what the cpu should read
    logic [31:0] lfsr_q;
    int rd_count;
    int wr_count;
    int mismatches;
    int other_errors;
    addr_t rd_last;
    addr_t wr_last;
    line_t wr_last_data;

    dcache_top dut0 (.*);

    always #10 clk = ~clk;

    // pattern uses all twelve address bits
    function automatic logic [7:0] fill_byte(input int a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    function automatic line_t gold_line(input addr_t a);
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[i*8 +: 8] = gold[{a[11:4], i[3:0]}];
        end
        return l;
    endfunction

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = (lfsr_q >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // memory model, refill three cycles after rd_req_o is seen
    initial begin
        int rd_wait;
        rd_wait = 0;
        rd_count = 0;
        wr_count = 0;
        ret_valid_i = 1'b0;
        ret_data_i = '0;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = fill_byte(a);
        end
        forever begin
            @(negedge clk);
            ret_valid_i = 1'b0;
            if (wr_req_o === 1'b1) begin
                wr_count++;
                wr_last = wr_addr_o;
                wr_last_data = wr_data_o;
                for (int i = 0; i < 16; i++) begin
                    mem[{wr_addr_o[11:4], i[3:0]}] = wr_data_o[i*8 +: 8];
                end
            end
            if (rd_req_o === 1'b1) begin
                if (rd_wait == 0) begin
                    rd_count++;
                    rd_last = rd_addr_o;
                end
                rd_wait++;
                if (rd_wait == 3) begin
                    rd_wait = 0;
                    for (int i = 0; i < 16; i++) begin
                        ret_data_i[i*8 +: 8] = mem[{rd_addr_o[11:4], i[3:0]}];
                    end
                    ret_valid_i = 1'b1;
                end
            end
        end
    end

    initial begin
        #((MAX_ACCESSES * (ACCESS_LIMIT + 2) + 50) * 20);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_val(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // one cpu access, lat is the rdata_valid_o cycle for reads, the release cycle for writes
    task automatic access(input logic we, input addr_t addr, input wstrb_t strb,
                          input word_t wdata, output word_t rdata, output int lat);
        int n;
        n = 0;
        lat = 0;
        rdata = '0;
        @(negedge clk);
        req_valid_i = 1'b1;
        req_we_i = we;
        req_addr_i = addr;
        req_wstrb_i = strb;
        req_wdata_i = wdata;
        do begin
            @(negedge clk);
            req_valid_i = 1'b0;   // stall_o was low, so it was taken
            #5;
            n++;
            if (!we && rdata_valid_o && lat == 0) begin
                rdata = rdata_o;
                lat = n;
            end
        end while (stall_o && n < ACCESS_LIMIT);
        if (stall_o) begin
            other_errors++;
            $display("access to %h still stalled after %0d cycles", addr, n);
        end else if (we) begin
            lat = n;
        end else if (lat == 0) begin
            other_errors++;
            $display("read of %h finished without rdata_valid_o", addr);
        end
    endtask

    task automatic check_read(input addr_t addr, output int lat);
        word_t got;
        word_t want;
        want = {gold[{addr[11:2], 2'd3}], gold[{addr[11:2], 2'd2}],
                gold[{addr[11:2], 2'd1}], gold[{addr[11:2], 2'd0}]};
        access(1'b0, addr, 4'h0, 32'h0, got, lat);
        if (got !== want) begin
            mismatches++;
            $display("Mismatch t=%0t rdata_o at %h got %h expected %h", $time, addr, got, want);
        end
    endtask

    task automatic write_word(input addr_t addr, input wstrb_t strb, input word_t data,
                              output int lat);
        word_t no_data;
        access(1'b1, addr, strb, data, no_data, lat);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                gold[{addr[11:2], b[1:0]}] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic read_miss_then_hits();
        int lat;
        int rd0;
        rd0 = rd_count;
        check_read(32'h0000_0138, lat);
        check_val("rd_req_o count", rd_count, rd0 + 1);
        check_val("rd_addr_o", rd_last, 32'h0000_0130);
        for (int w = 0; w < 4; w++) begin
            if (w != 2) begin
                check_read(32'h0000_0130 + w * 4, lat);
                check_val("rdata_valid_o latency", lat, 1);
            end
        end
        check_val("rd_req_o count", rd_count, rd0 + 1);
    endtask

    task automatic write_hit_strobes();
        int lat;
        int rd0;
        rd0 = rd_count;
        write_word(32'h0000_0134, 4'b0101, 32'hdead_beef, lat);
        check_val("write hit cycles", lat, 2);
        check_read(32'h0000_0134, lat);
        check_read(32'h0000_0138, lat);   // neighbour untouched
        check_val("rd_req_o count", rd_count, rd0);
    endtask

    task automatic write_miss_allocates();
        int lat;
        int rd0;
        rd0 = rd_count;
        write_word(32'h0000_0258, 4'b1110, 32'h1234_5678, lat);
        check_val("rd_req_o count", rd_count, rd0 + 1);
        check_val("rd_addr_o", rd_last, 32'h0000_0250);
        check_read(32'h0000_0258, lat);
        check_read(32'h0000_0250, lat);
        check_val("rd_req_o count", rd_count, rd0 + 1);
    endtask

    task automatic eviction_writeback();
        int lat;
        int rd0;
        int wr0;
        rd0 = rd_count;
        wr0 = wr_count;
        write_word(32'h0000_0194, 4'b1111, 32'hcafe_f00d, lat);   // way 0, dirty
        check_read(32'h0000_0290, lat);                            // way 1, clean
        check_read(32'h0000_0398, lat);
        check_val("wr_req_o count", wr_count, wr0 + 1);
        check_val("wr_addr_o", wr_last, 32'h0000_0190);
        if (wr_last_data !== gold_line(32'h0000_0190)) begin
            mismatches++;
            $display("Mismatch t=%0t wr_data_o got %h expected %h", $time, wr_last_data,
                     gold_line(32'h0000_0190));
        end
        check_read(32'h0000_019c, lat);   // clean victim this time
        check_val("wr_req_o count", wr_count, wr0 + 1);
        check_val("rd_req_o count", rd_count, rd0 + 4);
    endtask

    task automatic lru_replacement();
        int lat;
        int rd0;
        rd0 = rd_count;
        check_read(32'h0000_01c0, lat);
        check_read(32'h0000_02c0, lat);
        check_read(32'h0000_01c4, lat);   // touch the first way
        check_read(32'h0000_03c0, lat);
        check_val("rd_req_o count", rd_count, rd0 + 3);
        check_read(32'h0000_01c8, lat);
        check_val("rd_req_o count", rd_count, rd0 + 3);
        check_read(32'h0000_02c8, lat);   // this one went
        check_val("rd_req_o count", rd_count, rd0 + 4);
    endtask

    task automatic random_mix();
        word_t we;
        word_t idx;
        word_t tg;
        word_t wsel;
        word_t strb;
        word_t data;
        addr_t addr;
        int lat;
        for (int i = 0; i < 200; i++) begin
            we = rand_bits(1);
            idx = rand_bits(2);
            tg = rand_bits(3);
            wsel = rand_bits(2);
            addr = {21'h0, tg[2:0], 2'b00, idx[1:0], wsel[1:0], 2'b00};
            if (we[0]) begin
                strb = rand_bits(4);
                data = rand_bits(32);
                write_word(addr, strb[3:0], data, lat);
            end else begin
                check_read(addr, lat);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        req_valid_i = 1'b0;
        req_we_i = 1'b0;
        req_addr_i = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        lfsr_q = 32'h3e08_2a22;
        mismatches = 0;
        other_errors = 0;
        for (int a = 0; a < 4096; a++) begin
            gold[a] = fill_byte(a);
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        read_miss_then_hits();
        write_hit_strobes();
        write_miss_allocates();
        eviction_writeback();
        lru_replacement();
        random_mix();

        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
